/* Makefile */
TOOL      := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := lc3_step_tb
FILELIST  := lc3_step.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -F '** FAIL **' $(LOG) || ! grep -q -F '** PASS **' $(LOG); then \
		echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/lc3_data_memory.sv */
`default_nettype none

module lc3_data_memory
    import lc3_pkg::*;
#(
    parameter int MEM_WORDS = 128,
    localparam int ADDR_W = $clog2(MEM_WORDS)
) (
    input  logic              Clk5,
    input  logic              mem_wr_en,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic [WORD_W-1:0] store_word,
    input  logic [ADDR_W-1:0] disp_addr,
    output logic [WORD_W-1:0] mem_rdata,
    output logic [WORD_W-1:0] disp_mem_word
);

    logic [WORD_W-1:0] mem [MEM_WORDS];

    // Execution port, read data one cycle later
    always_ff @(posedge Clk5) begin
        if (mem_wr_en) begin
            mem[mem_addr] <= store_word;
        end
        mem_rdata <= mem[mem_addr];
    end

    assign disp_mem_word = mem[disp_addr];   // Display port

    a_wr_addr_known: assert property (@(posedge Clk5) mem_wr_en |-> !$isunknown(mem_addr));

endmodule

`default_nettype wire

/* hw/lc3_exec_control.sv */
`default_nettype none

module lc3_exec_control
    import lc3_pkg::*;
#(
    parameter int MEM_WORDS = 128,
    localparam int ADDR_W = $clog2(MEM_WORDS)
) (
    input  logic              Clk5,
    input  logic              state_reset,
    input  logic              instr_valid,
    input  logic [WORD_W-1:0] instr,
    input  logic [WORD_W-1:0] base_word,
    input  logic [2:0]        nzp,
    input  logic [WORD_W-1:0] mem_rdata,
    output logic              instr_ready,
    output lc3_instr_u        ir,
    output logic [1:0]        alu_op,
    output logic              wr_en,
    output logic [WORD_W-1:0] pass_word,
    output logic              mem_wr_en,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              disp_mem,
    output logic [7:0]        disp_index
);

    localparam logic [1:0] IDLE    = 2'd0;
    localparam logic [1:0] EXEC    = 2'd1;
    localparam logic [1:0] LOAD_WB = 2'd2;

    logic [1:0]        state;
    logic              busy;      // Instruction held, not yet retired
    logic              accept;
    logic [3:0]        opcode;
    logic [WORD_W-1:0] pc;
    logic [WORD_W-1:0] offset_sext;
    logic [WORD_W-1:0] rel_sum;
    logic              br_taken;

    assign accept      = instr_valid && instr_ready;
    assign instr_ready = ~busy;
    assign opcode      = ir.op.opcode;

    always_ff @(posedge Clk5) begin
        if (accept) begin
            ir <= instr;
        end
    end

    //////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////
    // Accept edge sets busy, the next IDLE cycle moves on to EXEC
    always_ff @(posedge Clk5 or posedge state_reset) begin
        if (state_reset) begin
            state <= IDLE;
            busy  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        busy <= 1'b1;
                    end else if (busy) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (opcode == OPC_LD) begin
                        state <= LOAD_WB;   // Wait for read data
                    end else begin
                        state <= IDLE;
                        busy  <= 1'b0;
                    end
                end
                LOAD_WB: begin
                    state <= IDLE;
                    busy  <= 1'b0;
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Address generation
    //////////////////////////////////////////////////
    assign offset_sext = {{(WORD_W-9){ir.pcrel.offset9[8]}}, ir.pcrel.offset9};
    assign rel_sum     = pc + offset_sext;
    assign br_taken    = |(ir.pcrel.dr_nzp & nzp);
    assign mem_addr    = rel_sum[ADDR_W-1:0];   // Wraps inside the memory
    assign mem_wr_en   = (state == EXEC) && (opcode == OPC_ST);
    assign pass_word   = (opcode == OPC_LD) ? mem_rdata : rel_sum;

    always_comb begin
        case (opcode)
            OPC_ADD: alu_op = ALU_ADD;
            OPC_AND: alu_op = ALU_AND;
            OPC_NOT: alu_op = ALU_NOT;
            default: alu_op = ALU_PASS;
        endcase
    end

    always_comb begin
        wr_en = 1'b0;
        if (state == LOAD_WB) begin
            wr_en = 1'b1;
        end else if (state == EXEC) begin
            wr_en = (opcode == OPC_ADD) || (opcode == OPC_AND) ||
                    (opcode == OPC_NOT) || (opcode == OPC_LEA);
        end
    end

    // PC moves only on BR and JMP
    always_ff @(posedge Clk5 or posedge state_reset) begin
        if (state_reset) begin
            pc         <= '0;
            disp_mem   <= 1'b0;
            disp_index <= '0;
        end else if (state == EXEC) begin
            case (opcode)
                OPC_BR: begin
                    if (br_taken) begin
                        pc <= rel_sum;
                    end
                end
                OPC_JMP: pc <= base_word;   // Base register
                OPC_OUT: begin
                    if (!ir.pcrel.dr_nzp[2]) begin
                        disp_mem   <= 1'b0;
                        disp_index <= {5'b0, ir.op.tail[2:0]};
                    end else if (ir.pcrel.dr_nzp == 3'b110) begin
                        disp_mem   <= 1'b1;
                        disp_index <= ir.pcrel.offset9[7:0];
                    end
                end
                default: ;
            endcase
        end
    end

    // No new instruction while one is being executed
    a_ready_only_idle: assert property (
        @(posedge Clk5) disable iff (state_reset)
        (state != IDLE) |-> !instr_ready
    );

endmodule

`default_nettype wire

/* hw/lc3_pkg.sv */
`default_nettype none

package lc3_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int WORD_W    = 16;
    localparam int REG_COUNT = 8;
    localparam int REG_IDX_W = 3;

    //////////////////////////////////////////////////
    // Opcodes, bits 15..12 of the instruction
    //////////////////////////////////////////////////
    localparam logic [3:0] OPC_BR  = 4'b0000;
    localparam logic [3:0] OPC_ADD = 4'b0001;
    localparam logic [3:0] OPC_LD  = 4'b0010;
    localparam logic [3:0] OPC_ST  = 4'b0011;
    localparam logic [3:0] OPC_AND = 4'b0101;
    localparam logic [3:0] OPC_NOT = 4'b1001;
    localparam logic [3:0] OPC_JMP = 4'b1100;
    localparam logic [3:0] OPC_OUT = 4'b1101;   // Display select
    localparam logic [3:0] OPC_LEA = 4'b1110;

    // ALU operations
    localparam logic [1:0] ALU_ADD  = 2'd0;
    localparam logic [1:0] ALU_AND  = 2'd1;
    localparam logic [1:0] ALU_NOT  = 2'd2;
    localparam logic [1:0] ALU_PASS = 2'd3;  // Load data or LEA sum

    // Operate format: ADD, AND, NOT, JMP, OUTPUT
    typedef struct packed {
        logic [3:0] opcode;
        logic [2:0] dr;
        logic [2:0] sr1;
        logic       imm;
        logic [4:0] tail;   // imm5, or sr2 in the low bits
    } lc3_op_s;

    // PC-relative format: BR, LD, ST, LEA
    typedef struct packed {
        logic [3:0] opcode;
        logic [2:0] dr_nzp;   // Destination, source or branch mask
        logic [8:0] offset9;
    } lc3_pcrel_s;

    typedef union packed {
        lc3_op_s    op;
        lc3_pcrel_s pcrel;
    } lc3_instr_u;

endpackage

`default_nettype wire

/* hw/lc3_reg_alu.sv */
`default_nettype none

module lc3_reg_alu
    import lc3_pkg::*;
(
    input  logic                 Clk5,
    input  logic                 state_reset,
    input  lc3_instr_u           ir,
    input  logic [1:0]           alu_op,
    input  logic                 wr_en,
    input  logic [WORD_W-1:0]    pass_word,
    input  logic [REG_IDX_W-1:0] disp_sel,
    output logic [WORD_W-1:0]    base_word,
    output logic [WORD_W-1:0]    store_word,
    output logic [2:0]           nzp,
    output logic [WORD_W-1:0]    disp_reg_word
);

    logic [WORD_W-1:0] regs [REG_COUNT];
    logic [WORD_W-1:0] operand_b;
    logic [WORD_W-1:0] alu_result;

    assign base_word     = regs[ir.op.sr1];
    assign store_word    = regs[ir.op.dr];   // Source of ST
    assign disp_reg_word = regs[disp_sel];

    // Immediate or second register
    assign operand_b = ir.op.imm ? {{(WORD_W-5){ir.op.tail[4]}}, ir.op.tail}
                                 : regs[ir.op.tail[2:0]];

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = base_word + operand_b;
            ALU_AND: alu_result = base_word & operand_b;
            ALU_NOT: alu_result = ~base_word;
            default: alu_result = pass_word;
        endcase
    end

    always_ff @(posedge Clk5 or posedge state_reset) begin
        if (state_reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            nzp <= 3'b010;   // Z only
        end else if (wr_en) begin
            regs[ir.op.dr] <= alu_result;
            if (alu_result[WORD_W-1]) begin
                nzp <= 3'b100;
            end else if (alu_result == '0) begin
                nzp <= 3'b010;
            end else begin
                nzp <= 3'b001;
            end
        end
    end

    a_nzp_onehot: assert property (@(posedge Clk5) disable iff (state_reset) $onehot(nzp));

endmodule

`default_nettype wire

/* hw/lc3_step_top.sv */
`default_nettype none

module lc3_step_top
    import lc3_pkg::*;
#(
    parameter int MEM_WORDS    = 128,
    parameter int DIGIT_CYCLES = 1000
) (
    input  logic              Clk5,
    input  logic              state_reset,
    input  logic              instr_valid,
    input  logic [WORD_W-1:0] instr,
    output logic              instr_ready,
    output logic [7:0]        an,
    output logic [6:0]        digit_x,
    output logic [2:0]        nzp
);

    localparam int ADDR_W = $clog2(MEM_WORDS);

    lc3_instr_u        ir;
    logic [1:0]        alu_op;
    logic              wr_en;
    logic [WORD_W-1:0] pass_word;
    logic [WORD_W-1:0] base_word;
    logic [WORD_W-1:0] store_word;
    logic              mem_wr_en;
    logic [ADDR_W-1:0] mem_addr;
    logic [WORD_W-1:0] mem_rdata;
    logic              disp_mem;
    logic [7:0]        disp_index;
    logic [WORD_W-1:0] disp_reg_word;
    logic [WORD_W-1:0] disp_mem_word;

    lc3_exec_control #(
        .MEM_WORDS(MEM_WORDS)
    ) lc3_exec_control_inst (
        .Clk5        (Clk5),
        .state_reset (state_reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .base_word   (base_word),
        .nzp         (nzp),
        .mem_rdata   (mem_rdata),
        .instr_ready (instr_ready),
        .ir          (ir),
        .alu_op      (alu_op),
        .wr_en       (wr_en),
        .pass_word   (pass_word),
        .mem_wr_en   (mem_wr_en),
        .mem_addr    (mem_addr),
        .disp_mem    (disp_mem),
        .disp_index  (disp_index)
    );

    lc3_reg_alu lc3_reg_alu_inst (
        .Clk5          (Clk5),
        .state_reset   (state_reset),
        .ir            (ir),
        .alu_op        (alu_op),
        .wr_en         (wr_en),
        .pass_word     (pass_word),
        .disp_sel      (disp_index[REG_IDX_W-1:0]),
        .base_word     (base_word),
        .store_word    (store_word),
        .nzp           (nzp),
        .disp_reg_word (disp_reg_word)
    );

    lc3_data_memory #(
        .MEM_WORDS(MEM_WORDS)
    ) lc3_data_memory_inst (
        .Clk5          (Clk5),
        .mem_wr_en     (mem_wr_en),
        .mem_addr      (mem_addr),
        .store_word    (store_word),
        .disp_addr     (disp_index[ADDR_W-1:0]),   // Index modulo depth
        .mem_rdata     (mem_rdata),
        .disp_mem_word (disp_mem_word)
    );

    seg_scan #(
        .DIGIT_CYCLES(DIGIT_CYCLES)
    ) seg_scan_inst (
        .Clk5          (Clk5),
        .state_reset   (state_reset),
        .disp_mem      (disp_mem),
        .disp_index    (disp_index),
        .disp_reg_word (disp_reg_word),
        .disp_mem_word (disp_mem_word),
        .an            (an),
        .digit_x       (digit_x)
    );

endmodule

`default_nettype wire

/* hw/seg_scan.sv */
`default_nettype none

module seg_scan
    import lc3_pkg::*;
#(
    parameter int DIGIT_CYCLES = 1000,
    localparam int CNT_W = $clog2(DIGIT_CYCLES + 1)
) (
    input  logic              Clk5,
    input  logic              state_reset,
    input  logic              disp_mem,
    input  logic [7:0]        disp_index,
    input  logic [WORD_W-1:0] disp_reg_word,
    input  logic [WORD_W-1:0] disp_mem_word,
    output logic [7:0]        an,
    output logic [6:0]        digit_x
);

    logic [CNT_W-1:0]  cycle_cnt;
    logic [2:0]        pos;          // 0 is the leftmost digit
    logic [WORD_W-1:0] shown_word;
    logic [4:0]        glyph_code;   // Bit 4 marks the letter r

    //////////////////////////////////////////////////
    // Digit scan
    //////////////////////////////////////////////////
    always_ff @(posedge Clk5 or posedge state_reset) begin
        if (state_reset) begin
            cycle_cnt <= '0;
            pos       <= '0;
        end else if (cycle_cnt == CNT_W'(DIGIT_CYCLES - 1)) begin
            cycle_cnt <= '0;
            pos       <= (pos == 3'd5) ? 3'd0 : pos + 3'd1;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    assign an = ~(8'h80 >> pos);   // Bits 1 and 0 never selected

    //////////////////////////////////////////////////
    // Display composition
    //////////////////////////////////////////////////
    assign shown_word = disp_mem ? disp_mem_word : disp_reg_word;

    always_comb begin
        case (pos)
            3'd0: glyph_code = {1'b0, shown_word[WORD_W-1 -: 4]};
            3'd1: glyph_code = {1'b0, shown_word[WORD_W-5 -: 4]};
            3'd2: glyph_code = {1'b0, shown_word[7:4]};
            3'd3: glyph_code = {1'b0, shown_word[3:0]};
            3'd4: glyph_code = disp_mem ? {1'b0, disp_index[7:4]} : 5'h10;
            default: glyph_code = {1'b0, disp_index[3:0]};   // Address low or reg number
        endcase
    end

    // Active low with segment g in bit 6
    always_comb begin
        case (glyph_code)
            5'h00: digit_x = 7'b1000000;
            5'h01: digit_x = 7'b1111001;
            5'h02: digit_x = 7'b0100100;
            5'h03: digit_x = 7'b0110000;
            5'h04: digit_x = 7'b0011001;
            5'h05: digit_x = 7'b0010010;
            5'h06: digit_x = 7'b0000010;
            5'h07: digit_x = 7'b1111000;
            5'h08: digit_x = 7'b0000000;
            5'h09: digit_x = 7'b0010000;
            5'h0a: digit_x = 7'b0001000;
            5'h0b: digit_x = 7'b0000011;
            5'h0c: digit_x = 7'b0100111;
            5'h0d: digit_x = 7'b0100001;
            5'h0e: digit_x = 7'b0000110;
            5'h0f: digit_x = 7'b0001110;
            5'h10: digit_x = 7'b0101111;   // r
            default: digit_x = 7'b1111111;
        endcase
    end

    // Only the six scanned digits ever light
    a_one_digit: assert property (
        @(posedge Clk5) disable iff (state_reset)
        $onehot(~an[7:2]) && (an[1:0] == 2'b11)
    );

endmodule

`default_nettype wire

/* lc3_step.f */
hw/lc3_pkg.sv
hw/lc3_exec_control.sv
hw/lc3_reg_alu.sv
hw/lc3_data_memory.sv
hw/seg_scan.sv
hw/lc3_step_top.sv
verification/lc3_step_checker.sv
verification/lc3_step_tb.sv

/* verification/lc3_step_checker.sv */
`default_nettype none

module lc3_step_checker
    import lc3_pkg::*;
(
    input  logic              Clk5,
    input  logic              state_reset,
    input  logic              instr_valid,
    input  logic [WORD_W-1:0] instr,
    input  logic              instr_ready,
    input  logic [7:0]        an,
    input  logic [6:0]        digit_x,
    input  logic [2:0]        nzp,
    output int                error_count,
    output int                accept_count,
    output int                check_count
);

    localparam int SCAN_HOLD = 4;   // Cycles per digit in the testbench

    // Active-low segments, entry 16 is the letter r
    localparam logic [6:0] GLYPHS [17] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h27, 7'h21, 7'h06, 7'h0e, 7'h2f
    };

    // Model of the processor state
    logic [WORD_W-1:0] m_regs [REG_COUNT];
    logic [WORD_W-1:0] m_mem [128];
    logic [WORD_W-1:0] m_pc;
    logic [2:0]        m_nzp;
    logic              m_disp_mem;
    logic [7:0]        m_disp_index;

    logic pending;       // Accepted, not yet retired
    int   exp_latency;
    int   low_cycles;
    int   last_pos;
    int   run_len;
    int   pos;
    int   got;
    int   want;

    task automatic flag_mismatch(input string msg);
        $display("Mismatch at %0t: %s", $time, msg);
        error_count++;
    endtask

    function automatic logic [2:0] sign_of(input logic [WORD_W-1:0] v);
        if (v[WORD_W-1]) begin
            return 3'b100;
        end else if (v == '0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    //////////////////////////////////////////////////
    // Reference model, returns cycles until ready
    //////////////////////////////////////////////////
    function automatic int apply_instr(input logic [WORD_W-1:0] w);
        logic [3:0]        op;
        logic [2:0]        dr;
        logic [WORD_W-1:0] b;
        logic [WORD_W-1:0] rel;
        logic [WORD_W-1:0] val;
        logic              wr;
        op  = w[15:12];
        dr  = w[11:9];
        b   = w[5] ? {{11{w[4]}}, w[4:0]} : m_regs[w[2:0]];
        rel = m_pc + {{7{w[8]}}, w[8:0]};
        wr  = 1'b1;
        val = '0;
        case (op)
            OPC_ADD: val = m_regs[w[8:6]] + b;
            OPC_AND: val = m_regs[w[8:6]] & b;
            OPC_NOT: val = ~m_regs[w[8:6]];
            OPC_LEA: val = rel;
            OPC_LD:  val = m_mem[rel[6:0]];
            default: wr = 1'b0;
        endcase
        if (wr) begin
            m_regs[dr] = val;
            m_nzp      = sign_of(val);
        end
        case (op)
            OPC_ST:  m_mem[rel[6:0]] = m_regs[dr];
            OPC_BR:  m_pc = ((dr & m_nzp) != 3'b000) ? rel : m_pc;
            OPC_JMP: m_pc = m_regs[w[8:6]];
            OPC_OUT: begin
                if (!dr[2]) begin
                    m_disp_mem   = 1'b0;
                    m_disp_index = {5'b00000, w[2:0]};
                end else if (dr == 3'b110) begin
                    m_disp_mem   = 1'b1;
                    m_disp_index = w[7:0];
                end
            end
            default: ;
        endcase
        return (op == OPC_LD) ? 3 : 2;
    endfunction

    function automatic int expected_glyph(input int p);
        logic [WORD_W-1:0] word;
        word = m_disp_mem ? m_mem[m_disp_index[6:0]] : m_regs[m_disp_index[2:0]];
        case (p)
            0: return int'(word[15:12]);
            1: return int'(word[11:8]);
            2: return int'(word[7:4]);
            3: return int'(word[3:0]);
            4: return m_disp_mem ? int'(m_disp_index[7:4]) : 16;
            default: return int'(m_disp_index[3:0]);
        endcase
    endfunction

    function automatic int glyph_value(input logic [6:0] seg);
        for (int i = 0; i < 17; i++) begin
            if (seg == GLYPHS[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int digit_position(input logic [7:0] pattern);
        for (int i = 0; i < 6; i++) begin
            if (pattern == ~(8'h80 >> i)) begin
                return i;
            end
        end
        return -1;
    endfunction

    //////////////////////////////////////////////////
    // Comparison, sampled at the falling edge
    //////////////////////////////////////////////////
    always @(negedge Clk5) begin
        if (state_reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                m_regs[i] = '0;
            end
            m_pc         = '0;
            m_nzp        = 3'b010;
            m_disp_mem   = 1'b0;
            m_disp_index = '0;
            pending      = 1'b0;
            last_pos     = -1;
            run_len      = 0;
            error_count  = 0;
            accept_count = 0;
            check_count  = 0;
        end else begin
            pos = digit_position(an);
            if (pos < 0) begin
                flag_mismatch($sformatf("an is %b, not one scanned digit", an));
            end else if (last_pos < 0) begin
                if (pos != 0) begin
                    flag_mismatch($sformatf("first digit after reset is %0d", pos));
                end
                run_len = 1;
            end else if (pos == last_pos) begin
                run_len++;
                if (run_len > SCAN_HOLD) begin
                    flag_mismatch($sformatf("digit %0d held %0d cycles", pos, run_len));
                end
            end else begin
                if (pos != (last_pos + 1) % 6 || run_len != SCAN_HOLD) begin
                    flag_mismatch($sformatf("scan went %0d to %0d after %0d cycles",
                                            last_pos, pos, run_len));
                end
                run_len = 1;
            end
            last_pos = pos;

            // Ready timing and condition codes
            if (pending) begin
                if (instr_ready) begin
                    if (low_cycles != exp_latency) begin
                        flag_mismatch($sformatf("ready returned after %0d cycles, expected %0d",
                                                low_cycles, exp_latency));
                    end
                    if (nzp !== m_nzp) begin
                        flag_mismatch($sformatf("nzp is %b, expected %b", nzp, m_nzp));
                    end
                    pending = 1'b0;
                end else begin
                    low_cycles++;
                end
            end else if (!instr_ready) begin
                flag_mismatch("ready is low with no instruction in flight");
            end

            if (!pending && instr_ready && pos >= 0) begin
                want = expected_glyph(pos);
                got  = glyph_value(digit_x);
                check_count++;
                if (got != want) begin
                    flag_mismatch($sformatf("digit %0d shows glyph %0d, expected %0d",
                                            pos, got, want));
                end
            end

            // Taken on the coming rising edge
            if (instr_valid && instr_ready) begin
                accept_count++;
                exp_latency = apply_instr(instr);
                low_cycles  = 0;
                pending     = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verification/lc3_step_tb.sv */
`default_nettype none

module lc3_step_tb
    import lc3_pkg::*;
();

    localparam int READY_TIMEOUT = 20;   // Cycles
    localparam int SCAN_TIMEOUT  = 60;

    logic              Clk5;
    logic              state_reset;
    logic              instr_valid;
    logic [WORD_W-1:0] instr;
    logic              instr_ready;
    logic [7:0]        an;
    logic [6:0]        digit_x;
    logic [2:0]        nzp;

    logic [15:0] lfsr_state;
    int          sent_count;
    int          timeout_count;
    int          mismatch_count;
    int          accept_count;
    int          digit_checks;
    int          fail_total;

    lc3_step_top #(
        .DIGIT_CYCLES(4)
    ) lc3_step_top_inst (
        .Clk5        (Clk5),
        .state_reset (state_reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .an          (an),
        .digit_x     (digit_x),
        .nzp         (nzp)
    );

    lc3_step_checker checker_inst (
        .Clk5         (Clk5),
        .state_reset  (state_reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .an           (an),
        .digit_x      (digit_x),
        .nzp          (nzp),
        .error_count  (mismatch_count),
        .accept_count (accept_count),
        .check_count  (digit_checks)
    );

    always #2 Clk5 = ~Clk5;

    //////////////////////////////////////////////////
    // Random bits and instruction words
    //////////////////////////////////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    function automatic logic [15:0] reg_form(input logic [3:0] opc, input logic [2:0] dr,
                                             input logic [2:0] sr1, input logic [2:0] sr2);
        return {opc, dr, sr1, 3'b000, sr2};
    endfunction

    function automatic logic [15:0] imm_form(input logic [3:0] opc, input logic [2:0] dr,
                                             input logic [2:0] sr1, input logic [4:0] imm5);
        return {opc, dr, sr1, 1'b1, imm5};
    endfunction

    function automatic logic [15:0] pcrel_form(input logic [3:0] opc, input logic [2:0] dr,
                                               input logic [8:0] off9);
        return {opc, dr, off9};
    endfunction

    function automatic int scan_position(input logic [7:0] pattern);
        for (int i = 0; i < 6; i++) begin
            if (pattern == ~(8'h80 >> i)) begin
                return i;
            end
        end
        return -1;
    endfunction

    //////////////////////////////////////////////////
    // Handshake and display waits
    //////////////////////////////////////////////////
    // Called one unit after a rising edge, returns the same way
    task automatic send_instr(input logic [15:0] word);
        int gap;
        int n;
        gap = int'(take_bits(2));
        repeat (gap) begin
            @(posedge Clk5);
            #1;
        end
        instr_valid = 1'b1;
        instr       = word;
        sent_count++;
        n = 0;
        do begin
            @(negedge Clk5);
            n++;
        end while (!instr_ready && n < READY_TIMEOUT);
        if (!instr_ready) begin
            $display("Timeout: instruction %h was never accepted", word);
            timeout_count++;
        end
        @(posedge Clk5);   // Accepting edge
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic await_idle();
        int n;
        n = 0;
        do begin
            @(negedge Clk5);
            n++;
        end while (!instr_ready && n < READY_TIMEOUT);
        if (!instr_ready) begin
            $display("Timeout: the DUT stayed busy and never raised ready");
            timeout_count++;
        end
        @(posedge Clk5);
        #1;
    endtask

    // Lets every digit position pass the checker once
    task automatic watch_full_scan();
        logic [5:0] seen;
        int         n;
        int         p;
        seen = '0;
        n    = 0;
        do begin
            @(negedge Clk5);
            p = scan_position(an);
            if (p >= 0) begin
                seen[p] = 1'b1;
            end
            n++;
        end while (seen != 6'h3f && n < SCAN_TIMEOUT);
        if (seen != 6'h3f) begin
            $display("Timeout: the display did not scan all six digits");
            timeout_count++;
        end
        @(posedge Clk5);
        #1;
    endtask

    task automatic show_register(input logic [2:0] r);
        send_instr({OPC_OUT, 3'b000, 6'b000000, r});
        await_idle();
        watch_full_scan();
    endtask

    task automatic view_memory(input logic [7:0] addr);
        send_instr({OPC_OUT, 3'b110, 1'b0, addr});
        await_idle();
        watch_full_scan();
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin
        logic [2:0] kind;
        logic [2:0] dr;
        logic [2:0] sr1;
        logic [2:0] sr2;
        logic [4:0] imm5;
        logic [8:0] off;
        Clk5          = 1'b0;
        state_reset   = 1'b1;
        instr_valid   = 1'b0;
        instr         = '0;
        lfsr_state    = 16'd33;
        sent_count    = 0;
        timeout_count = 0;
        repeat (5) @(posedge Clk5);
        #1;
        state_reset = 1'b0;
        watch_full_scan();   // R0 after reset

        // Operate instructions and LEA, PC stays at zero
        for (int k = 0; k < 20; k++) begin
            kind = 3'(take_bits(3));
            dr   = 3'(take_bits(3));
            sr1  = 3'(take_bits(3));
            sr2  = 3'(take_bits(3));
            imm5 = 5'(take_bits(5));
            off  = 9'(take_bits(9));
            case (kind)
                3'd0: send_instr(reg_form(OPC_ADD, dr, sr1, sr2));
                3'd2: send_instr(reg_form(OPC_AND, dr, sr1, sr2));
                3'd3: send_instr(imm_form(OPC_AND, dr, sr1, imm5));
                3'd4: send_instr({OPC_NOT, dr, sr1, 6'h3f});
                3'd5: send_instr(pcrel_form(OPC_LEA, dr, off));
                default: send_instr(imm_form(OPC_ADD, dr, sr1, imm5));
            endcase
            show_register(dr);
        end

        // Store then load, address is the low seven offset bits
        for (int k = 0; k < 6; k++) begin
            sr1 = 3'(take_bits(3));
            dr  = 3'(take_bits(3));
            off = 9'(take_bits(9));
            send_instr(pcrel_form(OPC_ST, sr1, off));
            send_instr(pcrel_form(OPC_LD, dr, off));
            show_register(dr);
            view_memory({1'b0, off[6:0]});
        end

        // Branches and jumps, seen through LEA
        for (int k = 0; k < 16; k++) begin
            kind = 3'(take_bits(2));
            dr   = 3'(take_bits(3));
            sr1  = 3'(take_bits(3));
            sr2  = 3'(take_bits(3));   // Branch mask
            imm5 = 5'(take_bits(5));
            off  = 9'(take_bits(9));
            case (kind)
                3'd0: send_instr(imm_form(OPC_ADD, sr1, sr1, imm5));
                3'd1: send_instr(imm_form(OPC_AND, sr1, sr1, imm5));
                default: ;
            endcase
            if (kind == 3'd3) begin
                send_instr({OPC_JMP, 3'b000, sr1, 6'b000000});
            end else begin
                send_instr(pcrel_form(OPC_BR, sr2, off));
            end
            send_instr(pcrel_form(OPC_LEA, dr, 9'(take_bits(9))));
            show_register(dr);
        end

        await_idle();
        if (accept_count != sent_count) begin
            $display("Accepted %0d instructions but %0d were sent", accept_count, sent_count);
        end
        if (digit_checks == 0) begin
            $display("No display digit was ever compared");
        end
        fail_total = mismatch_count + timeout_count;
        fail_total += (accept_count != sent_count) ? 1 : 0;
        fail_total += (digit_checks == 0) ? 1 : 0;
        $display("Errors: %0d mismatches, %0d timeouts, %0d of %0d accepted, %0d digit checks",
                 mismatch_count, timeout_count, accept_count, sent_count, digit_checks);
        if (fail_total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
